// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then \
		echo "Failure found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/data_ram.sv ====
module data_ram
    import rv32i_mem_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic Clk,
    input  logic arst_n_i,
    dmem_if.ram  dmem
);

    // Word storage, no reset
    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic [XLEN-1:0] rd_q;

    // ********************************************************
    // Byte-masked write port
    // ********************************************************

    always_ff @(posedge Clk) begin
        if (dmem.wr_en) begin
            // Each lane written only when its enable is set
            for (int i = 0; i < BE_W; i++) begin
                if (dmem.be[i]) begin
                    mem[dmem.word_idx][8*i +: 8] <= dmem.wr_data[8*i +: 8];
                end
            end
        end
    end

    // ********************************************************
    // Registered read
    // ********************************************************

    // Same-word write returns the old word
    always_ff @(posedge Clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_q <= '0;
        end else begin
            rd_q <= mem[dmem.word_idx];
        end
    end

    assign dmem.rd_data = rd_q;

endmodule

// ==== rtl/dmem_if.sv ====
interface dmem_if
    import rv32i_mem_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) ();

    // Word index into the RAM
    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [IDX_W-1:0] word_idx;
    logic             wr_en;
    // Byte lane mask, lane 0 is bits 7:0
    logic [BE_W-1:0]  be;
    logic [XLEN-1:0]  wr_data;
    // Word addressed in the previous cycle
    logic [XLEN-1:0]  rd_data;

    // Request formatter side
    modport ctrl (output word_idx, wr_en, be, wr_data);
    // RAM side
    modport ram (input word_idx, wr_en, be, wr_data, output rd_data);

endinterface

// ==== rtl/mem_load_extract.sv ====
module mem_load_extract
    import rv32i_mem_pkg::*;
(
    input  logic                  Clk,
    input  logic                  arst_n_i,
    mem_stage_if.dst              stage,
    input  logic [XLEN-1:0]       dmem_rd_data_i,
    output logic                  wb_valid_o,
    output logic [XLEN-1:0]       wb_load_data_o,
    output logic [XLEN-1:0]       wb_alu_result_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic                  wb_rf_wr_en_o,
    output logic                  wb_mem_to_reg_o,
    output logic                  wb_exception_o
);

    mem_op_e   op_q;
    logic [1:0] off_q;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // ********************************************************
    // Writeback field registers
    // ********************************************************

    // Control bits
    always_ff @(posedge Clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o      <= 1'b0;
            wb_rf_wr_en_o   <= 1'b0;
            wb_mem_to_reg_o <= 1'b0;
            wb_exception_o  <= 1'b0;
            op_q            <= MEM_NONE;
        end else begin
            wb_valid_o      <= stage.valid;
            wb_rf_wr_en_o   <= stage.rf_wr_en;
            wb_mem_to_reg_o <= stage.mem_to_reg;
            // Guard bit is always low, folded in harmlessly
            wb_exception_o  <= stage.exception | stage.op_unused_guard;
            op_q            <= stage.op;
        end
    end

    // Payload
    always_ff @(posedge Clk) begin
        off_q           <= stage.byte_off;
        wb_alu_result_o <= stage.alu_result;
        wb_rd_addr_o    <= stage.rd_addr;
    end

    // ********************************************************
    // Load lane select and extension
    // ********************************************************

    always_comb begin
        // Lane picked by registered offset
        case (off_q)
            2'd0:    byte_sel = dmem_rd_data_i[7:0];
            2'd1:    byte_sel = dmem_rd_data_i[15:8];
            2'd2:    byte_sel = dmem_rd_data_i[23:16];
            default: byte_sel = dmem_rd_data_i[31:24];
        endcase
        half_sel = off_q[1] ? dmem_rd_data_i[31:16] : dmem_rd_data_i[15:0];
    end

    always_comb begin
        if (!is_load(op_q)) begin
            // Nothing to return for stores and bubbles
            wb_load_data_o = '0;
        end else begin
            case (op_q)
                MEM_LB:  wb_load_data_o = {{(XLEN-8){byte_sel[7]}}, byte_sel};
                MEM_LBU: wb_load_data_o = {{(XLEN-8){1'b0}}, byte_sel};
                MEM_LH:  wb_load_data_o = {{(XLEN-16){half_sel[15]}}, half_sel};
                MEM_LHU: wb_load_data_o = {{(XLEN-16){1'b0}}, half_sel};
                default: wb_load_data_o = dmem_rd_data_i;
            endcase
        end
    end

endmodule

// ==== rtl/mem_req_format.sv ====
module mem_req_format
    import rv32i_mem_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic                  ex_valid_i,
    input  mem_op_e               ex_op_i,
    input  logic [XLEN-1:0]       ex_alu_result_i,
    input  logic [XLEN-1:0]       ex_rs2_data_i,
    input  logic                  fwd_sel_i,
    input  logic [XLEN-1:0]       fwd_data_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_addr_i,
    input  logic                  ex_rf_wr_en_i,
    input  logic                  ex_mem_to_reg_i,
    input  logic                  ex_exception_i,
    dmem_if.ctrl                  dmem,
    mem_stage_if.src              stage
);

    // Word index bits sit above the byte offset
    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] store_src;
    logic [1:0]      byte_off;
    logic            misaligned;
    logic [BE_W-1:0] lane_be;
    logic [XLEN-1:0] lane_data;
    logic            wr_ok;

    // ********************************************************
    // Store source and alignment check
    // ********************************************************

    // Forwarded writeback value wins over the regfile read
    assign store_src = fwd_sel_i ? fwd_data_i : ex_rs2_data_i;
    assign byte_off  = ex_alu_result_i[1:0];

    always_comb begin
        case (ex_op_i)
            // Halfwords need an even address
            MEM_LH, MEM_LHU, MEM_SH: misaligned = byte_off[0];
            // Words need offset zero
            MEM_LW, MEM_SW:          misaligned = (byte_off != 2'b00);
            // Bytes never misalign
            default:                 misaligned = 1'b0;
        endcase
    end

    // ********************************************************
    // Lane placement and byte enables
    // ********************************************************

    always_comb begin
        lane_be   = '0;
        lane_data = '0;
        case (ex_op_i)
            MEM_SB: begin
                // Byte moved to lane byte_off
                lane_be   = BE_W'(1) << byte_off;
                lane_data = XLEN'(store_src[7:0]) << {byte_off, 3'b000};
            end
            MEM_SH: begin
                // Upper or lower half by bit 1
                lane_be   = byte_off[1] ? 4'b1100 : 4'b0011;
                lane_data = XLEN'(store_src[15:0]) << {byte_off[1], 4'b0000};
            end
            MEM_SW: begin
                lane_be   = '1;
                lane_data = store_src;
            end
            default: begin
                lane_be   = '0;
                lane_data = '0;
            end
        endcase
    end

    // Only a valid, aligned store touches the RAM
    assign wr_ok = ex_valid_i && is_store(ex_op_i) && !misaligned;

    assign dmem.word_idx = ex_alu_result_i[IDX_W+1:2];
    assign dmem.wr_en    = wr_ok;
    assign dmem.be       = wr_ok ? lane_be : '0;
    assign dmem.wr_data  = lane_data;

    // Pipeline fields toward writeback
    assign stage.valid           = ex_valid_i;
    assign stage.op_unused_guard = 1'b0;
    assign stage.op              = ex_op_i;
    assign stage.byte_off        = byte_off;
    assign stage.alu_result      = ex_alu_result_i;
    assign stage.rd_addr         = ex_rd_addr_i;
    assign stage.rf_wr_en        = ex_rf_wr_en_i;
    assign stage.mem_to_reg      = ex_mem_to_reg_i;
    assign stage.exception       = ex_exception_i | misaligned;

endmodule

// ==== rtl/mem_stage_if.sv ====
interface mem_stage_if
    import rv32i_mem_pkg::*;
();

    // Operation qualifier
    logic                  valid;
    logic                  op_unused_guard;
    mem_op_e               op;
    // Low address bits, selects the load lane
    logic [1:0]            byte_off;
    logic [XLEN-1:0]       alu_result;
    // Writeback control
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  rf_wr_en;
    logic                  mem_to_reg;
    // Incoming exception merged with misalignment
    logic                  exception;

    // Driven by the request formatter
    modport src (output valid, op_unused_guard, op, byte_off, alu_result,
                 rd_addr, rf_wr_en, mem_to_reg, exception);

    // Registered by the load extractor
    modport dst (input valid, op_unused_guard, op, byte_off, alu_result,
                 rd_addr, rf_wr_en, mem_to_reg, exception);

endinterface

// ==== rtl/mem_stage_top.sv ====
module mem_stage_top
    import rv32i_mem_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic                  Clk,
    input  logic                  arst_n_i,
    // Execute stage request
    input  logic                  ex_valid_i,
    input  mem_op_e               ex_op_i,
    input  logic [XLEN-1:0]       ex_alu_result_i,
    input  logic [XLEN-1:0]       ex_rs2_data_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_addr_i,
    input  logic                  ex_rf_wr_en_i,
    input  logic                  ex_mem_to_reg_i,
    input  logic                  ex_exception_i,
    // Store data forwarding from writeback
    input  logic                  fwd_sel_i,
    input  logic [XLEN-1:0]       fwd_data_i,
    // Writeback stage result
    output logic                  wb_valid_o,
    output logic [XLEN-1:0]       wb_load_data_o,
    output logic [XLEN-1:0]       wb_alu_result_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic                  wb_rf_wr_en_o,
    output logic                  wb_mem_to_reg_o,
    output logic                  wb_exception_o
);

    // Formatter to RAM
    dmem_if #(.DMEM_WORDS(DMEM_WORDS)) dmem_bus ();
    // Formatter to load extractor
    mem_stage_if stage_bus ();

    mem_req_format #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_req_format (
        .ex_valid_i      (ex_valid_i),
        .ex_op_i         (ex_op_i),
        .ex_alu_result_i (ex_alu_result_i),
        .ex_rs2_data_i   (ex_rs2_data_i),
        .fwd_sel_i       (fwd_sel_i),
        .fwd_data_i      (fwd_data_i),
        .ex_rd_addr_i    (ex_rd_addr_i),
        .ex_rf_wr_en_i   (ex_rf_wr_en_i),
        .ex_mem_to_reg_i (ex_mem_to_reg_i),
        .ex_exception_i  (ex_exception_i),
        .dmem            (dmem_bus.ctrl),
        .stage           (stage_bus.src)
    );

    data_ram #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_data_ram (
        .Clk      (Clk),
        .arst_n_i (arst_n_i),
        .dmem     (dmem_bus.ram)
    );

    // Read data tapped straight off the RAM bus
    mem_load_extract u_load_extract (
        .Clk             (Clk),
        .arst_n_i        (arst_n_i),
        .stage           (stage_bus.dst),
        .dmem_rd_data_i  (dmem_bus.rd_data),
        .wb_valid_o      (wb_valid_o),
        .wb_load_data_o  (wb_load_data_o),
        .wb_alu_result_o (wb_alu_result_o),
        .wb_rd_addr_o    (wb_rd_addr_o),
        .wb_rf_wr_en_o   (wb_rf_wr_en_o),
        .wb_mem_to_reg_o (wb_mem_to_reg_o),
        .wb_exception_o  (wb_exception_o)
    );

endmodule

// ==== rtl/rv32i_mem_pkg.sv ====
package rv32i_mem_pkg;

    // Datapath word width
    localparam int XLEN       = 32;
    // Register file index width
    localparam int REG_ADDR_W = 5;
    // One write enable per byte lane
    localparam int BE_W       = XLEN / 8;

    // Memory operation handed down from decode
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // Any load, signed or unsigned
    function automatic logic is_load(input mem_op_e op);
        return (op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU});
    endfunction

    // Any store width
    function automatic logic is_store(input mem_op_e op);
        return (op inside {MEM_SB, MEM_SH, MEM_SW});
    endfunction

endpackage

// ==== src.f ====
rtl/rv32i_mem_pkg.sv
rtl/dmem_if.sv
rtl/mem_stage_if.sv
rtl/mem_req_format.sv
rtl/data_ram.sv
rtl/mem_load_extract.sv
rtl/mem_stage_top.sv
tb/mem_stage_sva.sv
tb/mem_stage_tb.sv

// ==== tb/mem_stage_sva.sv ====
module mem_stage_sva
    import rv32i_mem_pkg::*;
(
    input logic                  Clk,
    input logic                  arst_n_i,
    input logic                  ex_valid_i,
    input mem_op_e               ex_op_i,
    input logic [XLEN-1:0]       ex_alu_result_i,
    input logic [REG_ADDR_W-1:0] ex_rd_addr_i,
    input logic                  ex_rf_wr_en_i,
    input logic                  ex_mem_to_reg_i,
    input logic                  ex_exception_i,
    input logic                  dmem_wr_en_i,
    input logic [BE_W-1:0]       dmem_be_i,
    input logic                  wb_valid_o,
    input logic [XLEN-1:0]       wb_alu_result_o,
    input logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    input logic                  wb_rf_wr_en_o,
    input logic                  wb_mem_to_reg_o,
    input logic                  wb_exception_o
);

    // Failed assertions so far, read by the testbench
    int unsigned fail_count = 0;
    logic        misal;

    // Halfword at odd address, word at any nonzero offset
    assign misal = ((ex_op_i inside {MEM_LH, MEM_LHU, MEM_SH}) && ex_alu_result_i[0])
                || ((ex_op_i inside {MEM_LW, MEM_SW}) && (ex_alu_result_i[1:0] != 2'b00));

    // ************************************************************
    // Write suppression and exception
    // ************************************************************

    a_no_misaligned_write: assert property (@(posedge Clk) disable iff (!arst_n_i)
        misal |-> (!dmem_wr_en_i && (dmem_be_i == '0)))
        else begin
            fail_count++;
            $error("RAM write enabled on a misaligned access");
        end

    // Incoming exception merged with misalignment
    a_exception: assert property (@(posedge Clk) disable iff (!arst_n_i)
        1'b1 |=> (wb_exception_o == $past(ex_exception_i || misal)))
        else begin
            fail_count++;
            $error("wb exception does not follow the previous request");
        end

    // ************************************************************
    // Pass-through and reset
    // ************************************************************

    a_pass_through: assert property (@(posedge Clk) disable iff (!arst_n_i)
        1'b1 |=> ((wb_valid_o == $past(ex_valid_i))
               && (wb_rd_addr_o == $past(ex_rd_addr_i))
               && (wb_rf_wr_en_o == $past(ex_rf_wr_en_i))
               && (wb_mem_to_reg_o == $past(ex_mem_to_reg_i))
               && (wb_alu_result_o == $past(ex_alu_result_i))))
        else begin
            fail_count++;
            $error("wb fields differ from the previous ex inputs");
        end

    a_reset_quiet: assert property (@(posedge Clk)
        !arst_n_i |-> (!wb_valid_o && !wb_rf_wr_en_o && !wb_exception_o))
        else begin
            fail_count++;
            $error("wb control bits active during reset");
        end

endmodule

// Attached to every instance of the stage top
bind mem_stage_top mem_stage_sva u_sva (
    .Clk             (Clk),
    .arst_n_i        (arst_n_i),
    .ex_valid_i      (ex_valid_i),
    .ex_op_i         (ex_op_i),
    .ex_alu_result_i (ex_alu_result_i),
    .ex_rd_addr_i    (ex_rd_addr_i),
    .ex_rf_wr_en_i   (ex_rf_wr_en_i),
    .ex_mem_to_reg_i (ex_mem_to_reg_i),
    .ex_exception_i  (ex_exception_i),
    .dmem_wr_en_i    (dmem_bus.wr_en),
    .dmem_be_i       (dmem_bus.be),
    .wb_valid_o      (wb_valid_o),
    .wb_alu_result_o (wb_alu_result_o),
    .wb_rd_addr_o    (wb_rd_addr_o),
    .wb_rf_wr_en_o   (wb_rf_wr_en_o),
    .wb_mem_to_reg_o (wb_mem_to_reg_o),
    .wb_exception_o  (wb_exception_o)
);

// ==== tb/mem_stage_tb.sv ====
module mem_stage_tb;
    import rv32i_mem_pkg::*;

    localparam int DMEM_WORDS = 256;
    localparam int IDX_W      = $clog2(DMEM_WORDS);
    // Ops per test incl. closing bubble, then the random run
    localparam int FIXED_OPS  = 17 + 15 + 9 + 10 + 6 + 9;
    localparam int RAND_OPS   = 40;
    localparam int LIMIT_NS   = (FIXED_OPS + RAND_OPS + 4 + 100) * 10;

    logic                  Clk;
    logic                  arst_n_i;
    logic                  ex_valid_i;
    mem_op_e               ex_op_i;
    logic [XLEN-1:0]       ex_alu_result_i;
    logic [XLEN-1:0]       ex_rs2_data_i;
    logic [REG_ADDR_W-1:0] ex_rd_addr_i;
    logic                  ex_rf_wr_en_i;
    logic                  ex_mem_to_reg_i;
    logic                  ex_exception_i;
    logic                  fwd_sel_i;
    logic [XLEN-1:0]       fwd_data_i;
    logic                  wb_valid_o;
    logic [XLEN-1:0]       wb_load_data_o;
    logic [XLEN-1:0]       wb_alu_result_o;
    logic [REG_ADDR_W-1:0] wb_rd_addr_o;
    logic                  wb_rf_wr_en_o;
    logic                  wb_mem_to_reg_o;
    logic                  wb_exception_o;

    // Shadow of the data RAM
    logic [31:0] shadow [DMEM_WORDS];
    integer      seed;
    string       test_name;
    int          test_err;
    int          pass_cnt;
    int          fail_cnt;
    int unsigned sva_base;

    mem_stage_top #(.DMEM_WORDS(DMEM_WORDS)) u_dut (.*);

    always #5 Clk = ~Clk;

    // Alignment rule for halfword and word accesses
    function automatic logic misaligned(input mem_op_e op, input logic [1:0] off);
        if (op inside {MEM_LH, MEM_LHU, MEM_SH}) return off[0];
        if (op inside {MEM_LW, MEM_SW}) return off != 2'b00;
        return 1'b0;
    endfunction

    // Merge a store into the shadow word through a lane mask
    function automatic void apply_store(input mem_op_e op, input logic [31:0] addr,
                                        input logic [31:0] data);
        logic [31:0] mask;
        logic [31:0] val;
        mask = '0;
        val  = data;
        case (op)
            MEM_SB: begin
                mask = 32'h0000_00ff << {addr[1:0], 3'b000};
                val  = {4{data[7:0]}};
            end
            MEM_SH: begin
                mask = 32'h0000_ffff << {addr[1], 4'b0000};
                val  = {2{data[15:0]}};
            end
            MEM_SW: mask = '1;
            default: mask = '0;
        endcase
        shadow[addr[IDX_W+1:2]] = (shadow[addr[IDX_W+1:2]] & ~mask) | (val & mask);
    endfunction

    // Expected writeback data of a load
    function automatic logic [31:0] predict_load(input mem_op_e op, input logic [31:0] addr);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = shadow[addr[IDX_W+1:2]];
        b = 8'(w >> {addr[1:0], 3'b000});
        h = 16'(w >> {addr[1], 4'b0000});
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'd0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'd0, h};
            MEM_LW:  return w;
            default: return '0;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %08h, actual %08h", test_name, what, exp, act);
            test_err++;
        end
    endtask

    // One request, then the writeback cycle that follows it
    task automatic issue(input mem_op_e op, input logic [31:0] addr, input logic [31:0] rs2,
                         input logic sel, input logic [31:0] fwd, input logic valid);
        logic        bad;
        logic        is_ld;
        logic [31:0] exp;
        bad   = misaligned(op, addr[1:0]);
        is_ld = op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
        exp   = predict_load(op, addr);
        ex_valid_i      = valid;
        ex_op_i         = op;
        ex_alu_result_i = addr;
        ex_rs2_data_i   = rs2;
        fwd_sel_i       = sel;
        fwd_data_i      = fwd;
        // Sideband fields only flow through
        ex_rd_addr_i    = 5'($random(seed));
        ex_rf_wr_en_i   = 1'($random(seed));
        ex_mem_to_reg_i = 1'($random(seed));
        ex_exception_i  = 1'($random(seed));
        if (valid && !bad) begin
            apply_store(op, addr, sel ? fwd : rs2);
        end
        @(posedge Clk);
        #1;
        if (valid && is_ld && !bad) check(op.name(), exp, wb_load_data_o);
        // Stores and bubbles return no load data
        if (!is_ld) check("no_load", 32'd0, wb_load_data_o);
        if (valid && bad) check("exception", 32'd1, {31'd0, wb_exception_o});
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err  = 0;
        sva_base  = u_dut.u_sva.fail_count;
    endtask

    task automatic end_test();
        int errs;
        // Bubble lets the last assertion resolve
        issue(MEM_NONE, '0, '0, 1'b0, '0, 1'b0);
        errs = test_err + int'(u_dut.u_sva.fail_count - sva_base);
        if (errs == 0) begin
            pass_cnt++;
            $display("Test %s: ok", test_name);
        end else begin
            fail_cnt++;
            $display("Test %s: %0d errors", test_name, errs);
        end
    endtask

    // Watchdog
    initial begin
        #(LIMIT_NS);
        $display("Timeout: tests still running after %0d time units", LIMIT_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] b;
        seed = 32'h7921_43d3;
        pass_cnt = 0;
        fail_cnt = 0;
        Clk = 1'b0;
        arst_n_i = 1'b1;
        ex_valid_i = 1'b0;
        ex_op_i = MEM_NONE;
        ex_alu_result_i = '0;
        ex_rs2_data_i = '0;
        ex_rd_addr_i = '0;
        ex_rf_wr_en_i = 1'b0;
        ex_mem_to_reg_i = 1'b0;
        ex_exception_i = 1'b0;
        fwd_sel_i = 1'b0;
        fwd_data_i = '0;
        // Clean falling edge, then 3 clocks in reset
        #1 arst_n_i = 1'b0;
        repeat (3) @(posedge Clk);
        #1 arst_n_i = 1'b1;

        begin_test("word_round_trip");
        for (int i = 0; i < 8; i++) issue(MEM_SW, 32'h40 + 4 * i, $random(seed), 1'b0, '0, 1'b1);
        for (int i = 0; i < 8; i++) issue(MEM_LW, 32'h40 + 4 * i, '0, 1'b0, '0, 1'b1);
        end_test();

        begin_test("byte_lanes");
        issue(MEM_SW, 32'h100, $random(seed), 1'b0, '0, 1'b1);
        for (int i = 0; i < 4; i++) issue(MEM_SB, 32'h100 + i, $random(seed), 1'b0, '0, 1'b1);
        for (int i = 0; i < 4; i++) begin
            issue(MEM_LB, 32'h100 + i, '0, 1'b0, '0, 1'b1);
            issue(MEM_LBU, 32'h100 + i, '0, 1'b0, '0, 1'b1);
        end
        issue(MEM_LW, 32'h100, '0, 1'b0, '0, 1'b1);
        end_test();

        begin_test("halfwords");
        issue(MEM_SW, 32'h200, $random(seed), 1'b0, '0, 1'b1);
        issue(MEM_SH, 32'h200, 32'h0000_8a31, 1'b0, '0, 1'b1);
        issue(MEM_SH, 32'h202, $random(seed), 1'b0, '0, 1'b1);
        for (int i = 0; i < 4; i += 2) begin
            issue(MEM_LH, 32'h200 + i, '0, 1'b0, '0, 1'b1);
            issue(MEM_LHU, 32'h200 + i, '0, 1'b0, '0, 1'b1);
        end
        issue(MEM_LW, 32'h200, '0, 1'b0, '0, 1'b1);
        end_test();

        begin_test("misaligned");
        issue(MEM_SW, 32'h300, 32'h1234_5678, 1'b0, '0, 1'b1);
        issue(MEM_SH, 32'h301, $random(seed), 1'b0, '0, 1'b1);
        issue(MEM_SH, 32'h303, $random(seed), 1'b0, '0, 1'b1);
        for (int i = 1; i < 4; i++) issue(MEM_SW, 32'h300 + i, $random(seed), 1'b0, '0, 1'b1);
        issue(MEM_LH, 32'h301, '0, 1'b0, '0, 1'b1);
        issue(MEM_LW, 32'h302, '0, 1'b0, '0, 1'b1);
        // Word must still hold the first store
        issue(MEM_LW, 32'h300, '0, 1'b0, '0, 1'b1);
        end_test();

        begin_test("forwarding");
        a = $random(seed);
        b = ~a;
        issue(MEM_SW, 32'h400, b, 1'b1, a, 1'b1);
        issue(MEM_LW, 32'h400, '0, 1'b0, '0, 1'b1);
        issue(MEM_SB, 32'h401, a, 1'b1, b, 1'b1);
        issue(MEM_LBU, 32'h401, '0, 1'b0, '0, 1'b1);
        issue(MEM_LW, 32'h400, '0, 1'b0, '0, 1'b1);
        end_test();

        begin_test("random_pass_through");
        for (int i = 0; i < 8; i++) issue(MEM_SW, 32'h500 + 4 * i, $random(seed), 1'b0, '0, 1'b1);
        for (int i = 0; i < RAND_OPS; i++) begin
            rnd = $random(seed);
            a = $random(seed);
            b = $random(seed);
            // Ops over eight words, any offset, some bubbles
            issue(mem_op_e'(rnd[3:0] % 4'd9), 32'h500 + {27'd0, rnd[8:4]}, a, rnd[9], b,
                  rnd[10] | rnd[11]);
        end
        end_test();

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
